//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module alu_cluster_tb -f sim.f -Mdir obj_dir \
  || { echo "build failed"; exit 1; }
sim_out=$(./obj_dir/Valu_cluster_tb +verilator+error+limit+100 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Simulation PASSED" \
  && echo "run passed" \
  || { echo "run failed"; exit 1; }

//--- sim.f
source/alu_pkg.sv
source/issue_dispatch.sv
source/alu_lane.sv
source/result_collector.sv
source/alu_cluster.sv
tests/alu_cluster_checker.sv
tests/alu_cluster_tb.sv

//--- source/alu_cluster.sv
module alu_cluster #(
  parameter int N_LANES = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  alu_pkg::alu_req_t  in_req,
  output logic               in_ready,
  output logic               out_valid,
  output alu_pkg::alu_resp_t out_resp,
  input  logic               out_ready
);

  logic [N_LANES-1:0]                lane_valid;
  logic [N_LANES-1:0]                lane_ready;
  alu_pkg::alu_req_t [N_LANES-1:0]   lane_req;
  logic [N_LANES-1:0]                resp_valid;
  logic [N_LANES-1:0]                resp_ready;
  alu_pkg::alu_resp_t [N_LANES-1:0]  lane_resp;

  issue_dispatch #(
    .N_LANES (N_LANES)
  ) u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_ready   (in_ready),
    .lane_valid (lane_valid),
    .lane_req   (lane_req),
    .lane_ready (lane_ready)
  );

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    alu_lane u_lane (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (lane_valid[i]),
      .req        (lane_req[i]),
      .req_ready  (lane_ready[i]),
      .resp_valid (resp_valid[i]),
      .resp       (lane_resp[i]),
      .resp_ready (resp_ready[i])
    );
  end

  result_collector #(
    .N_LANES (N_LANES)
  ) u_collector (
    .clk        (clk),
    .rst        (rst),
    .resp_valid (resp_valid),
    .resp       (lane_resp),
    .resp_ready (resp_ready),
    .out_valid  (out_valid),
    .out_resp   (out_resp),
    .out_ready  (out_ready)
  );

endmodule

//--- source/alu_lane.sv
module alu_lane (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_valid,
  input  alu_pkg::alu_req_t  req,
  output logic               req_ready,
  output logic               resp_valid,
  output alu_pkg::alu_resp_t resp,
  input  logic               resp_ready
);

  function automatic logic cond_holds(input alu_pkg::cond_t cond,
                                      input alu_pkg::flags_t fl);
    logic holds;
    holds = 1'b0;
    case (cond)
      alu_pkg::COND_AL: holds = 1'b1;
      alu_pkg::COND_NV: holds = 1'b0;
      alu_pkg::COND_EQ: holds = fl.zero;
      alu_pkg::COND_NE: holds = !fl.zero;
      alu_pkg::COND_CS: holds = fl.carry;
      alu_pkg::COND_CC: holds = !fl.carry;
      alu_pkg::COND_MI: holds = fl.negative;
      alu_pkg::COND_PL: holds = !fl.negative;
      alu_pkg::COND_VS: holds = fl.overflow;
      alu_pkg::COND_VC: holds = !fl.overflow;
      // unsigned compares
      alu_pkg::COND_HI: holds = fl.carry && !fl.zero;
      alu_pkg::COND_LS: holds = !fl.carry || fl.zero;
      // signed compares
      alu_pkg::COND_GE: holds = fl.negative == fl.overflow;
      alu_pkg::COND_LT: holds = fl.negative != fl.overflow;
      alu_pkg::COND_GT: holds = !fl.zero && (fl.negative == fl.overflow);
      alu_pkg::COND_LE: holds = fl.zero || (fl.negative != fl.overflow);
    endcase
    return holds;
  endfunction

  logic                         stall;
  logic                         s1_valid;
  alu_pkg::alu_req_t            s1_req;
  logic                         s1_exec;

  logic                         sub_op;
  alu_pkg::data_t               b_eff;
  logic [alu_pkg::DATA_W:0]     sum_ext;
  logic                         add_ovf;
  logic [alu_pkg::SHAMT_W-1:0]  shamt;
  alu_pkg::data_t               op_result;
  alu_pkg::flags_t              op_flags;
  alu_pkg::alu_resp_t           exec_resp;

  // output stalled holds the pipe; stage one can still fill if empty
  assign stall     = resp_valid && !resp_ready;
  assign req_ready = !(stall && s1_valid);

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else if (req_ready) begin
      s1_valid <= req_valid;
    end
  end

  // condition resolved on entry, carried with the request
  always_ff @(posedge clk) begin
    if (req_ready && req_valid) begin
      s1_req  <= req;
      s1_exec <= cond_holds(req.cond, req.flags_in);
    end
  end

  // shared adder, sub as a + ~b + 1
  assign sub_op  = (s1_req.op == alu_pkg::OP_SUB);
  assign b_eff   = sub_op ? ~s1_req.b : s1_req.b;
  assign sum_ext = {1'b0, s1_req.a} + {1'b0, b_eff} + {{alu_pkg::DATA_W{1'b0}}, sub_op};
  assign add_ovf = (s1_req.a[alu_pkg::DATA_W-1] == b_eff[alu_pkg::DATA_W-1]) &&
                   (sum_ext[alu_pkg::DATA_W-1] != s1_req.a[alu_pkg::DATA_W-1]);
  assign shamt   = s1_req.b[alu_pkg::SHAMT_W-1:0];

  always_comb begin
    op_result         = s1_req.a;
    op_flags.carry    = 1'b0;
    op_flags.overflow = 1'b0;
    case (s1_req.op)
      alu_pkg::OP_ADD, alu_pkg::OP_SUB: begin
        op_result         = sum_ext[alu_pkg::DATA_W-1:0];
        // for sub this is the no-borrow carry
        op_flags.carry    = sum_ext[alu_pkg::DATA_W];
        op_flags.overflow = add_ovf;
      end
      alu_pkg::OP_AND: op_result = s1_req.a & s1_req.b;
      alu_pkg::OP_OR:  op_result = s1_req.a | s1_req.b;
      alu_pkg::OP_XOR: op_result = s1_req.a ^ s1_req.b;
      alu_pkg::OP_SHL: op_result = s1_req.a << shamt;
      alu_pkg::OP_SHR: op_result = s1_req.a >> shamt;
      alu_pkg::OP_SRA: op_result = alu_pkg::data_t'($signed(s1_req.a) >>> shamt);
    endcase
    op_flags.negative = op_result[alu_pkg::DATA_W-1];
    op_flags.zero     = (op_result == '0);
  end

  // failed condition passes a and the incoming flags through
  always_comb begin
    if (s1_exec) begin
      exec_resp.result   = op_result;
      exec_resp.flags    = op_flags;
      exec_resp.executed = 1'b1;
    end else begin
      exec_resp.result   = s1_req.a;
      exec_resp.flags    = s1_req.flags_in;
      exec_resp.executed = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      resp_valid <= 1'b0;
    end else if (!stall) begin
      resp_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && s1_valid) begin
      resp <= exec_resp;
    end
  end

endmodule

//--- source/alu_pkg.sv
package alu_pkg;

  localparam int DATA_W  = 64;
  localparam int SHAMT_W = 6;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [2:0]        opcode_t;
  typedef logic [3:0]        cond_t;

  localparam opcode_t OP_ADD = 3'd0;
  localparam opcode_t OP_SUB = 3'd1;
  localparam opcode_t OP_AND = 3'd2;
  localparam opcode_t OP_OR  = 3'd3;
  localparam opcode_t OP_XOR = 3'd4;
  localparam opcode_t OP_SHL = 3'd5;
  localparam opcode_t OP_SHR = 3'd6;
  localparam opcode_t OP_SRA = 3'd7;

  // condition codes, tested against flags_in
  localparam cond_t COND_AL = 4'd0;
  localparam cond_t COND_NV = 4'd1;
  localparam cond_t COND_EQ = 4'd2;
  localparam cond_t COND_NE = 4'd3;
  localparam cond_t COND_CS = 4'd4;
  localparam cond_t COND_CC = 4'd5;
  localparam cond_t COND_MI = 4'd6;
  localparam cond_t COND_PL = 4'd7;
  localparam cond_t COND_VS = 4'd8;
  localparam cond_t COND_VC = 4'd9;
  localparam cond_t COND_HI = 4'd10;
  localparam cond_t COND_LS = 4'd11;
  localparam cond_t COND_GE = 4'd12;
  localparam cond_t COND_LT = 4'd13;
  localparam cond_t COND_GT = 4'd14;
  localparam cond_t COND_LE = 4'd15;

  typedef struct packed {
    logic carry;
    logic overflow;
    logic negative;
    logic zero;
  } flags_t;

  typedef struct packed {
    opcode_t op;
    cond_t   cond;
    data_t   a;
    data_t   b;
    flags_t  flags_in;
  } alu_req_t;

  typedef struct packed {
    data_t  result;
    flags_t flags;
    logic   executed;
  } alu_resp_t;

endpackage

//--- source/issue_dispatch.sv
module issue_dispatch #(
  parameter int N_LANES = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                in_valid,
  input  alu_pkg::alu_req_t                   in_req,
  output logic                                in_ready,
  output logic [N_LANES-1:0]                  lane_valid,
  output alu_pkg::alu_req_t [N_LANES-1:0]     lane_req,
  input  logic [N_LANES-1:0]                  lane_ready
);

  // one bit minimum so a single lane still elaborates
  localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  logic [PTR_W-1:0] issue_ptr;
  logic [PTR_W-1:0] issue_ptr_next;
  logic             issue_fire;

  assign in_ready   = lane_ready[issue_ptr];
  assign issue_fire = in_valid && in_ready;

  always_comb begin
    if (issue_ptr == PTR_W'(N_LANES - 1)) begin
      issue_ptr_next = '0;
    end else begin
      issue_ptr_next = issue_ptr + 1'b1;
    end
  end

  // only the selected lane sees valid
  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      lane_valid[i] = in_valid && (issue_ptr == PTR_W'(i));
      lane_req[i]   = in_req;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      issue_ptr <= '0;
    end else if (issue_fire) begin
      issue_ptr <= issue_ptr_next;
    end
  end

endmodule

//--- source/result_collector.sv
module result_collector #(
  parameter int N_LANES = 4
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [N_LANES-1:0]                  resp_valid,
  input  alu_pkg::alu_resp_t [N_LANES-1:0]    resp,
  output logic [N_LANES-1:0]                  resp_ready,
  output logic                                out_valid,
  output alu_pkg::alu_resp_t                  out_resp,
  input  logic                                out_ready
);

  localparam int PTR_W = (N_LANES > 1) ? $clog2(N_LANES) : 1;

  logic [PTR_W-1:0] drain_ptr;
  logic [PTR_W-1:0] drain_ptr_next;
  logic             drain_fire;

  // follows the issue order, so no tags are needed
  assign out_valid  = resp_valid[drain_ptr];
  assign out_resp   = resp[drain_ptr];
  assign drain_fire = out_valid && out_ready;

  always_comb begin
    if (drain_ptr == PTR_W'(N_LANES - 1)) begin
      drain_ptr_next = '0;
    end else begin
      drain_ptr_next = drain_ptr + 1'b1;
    end
  end

  // other lanes keep their results until their turn
  always_comb begin
    for (int i = 0; i < N_LANES; i++) begin
      resp_ready[i] = out_ready && (drain_ptr == PTR_W'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drain_ptr <= '0;
    end else if (drain_fire) begin
      drain_ptr <= drain_ptr_next;
    end
  end

endmodule

//--- tests/alu_cluster_checker.sv
module alu_cluster_checker (
  input logic               clk,
  input logic               rst,
  input logic               in_valid,
  input logic               in_ready,
  input alu_pkg::alu_req_t  in_req,
  input logic               out_valid,
  input logic               out_ready,
  input alu_pkg::alu_resp_t out_resp
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // from the second reset edge on, the first may see power-up values
  out_low_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !out_valid)
    else begin
      $error("out_valid high during reset");
      fail_count++;
    end

  in_held: assert property (@(posedge clk) disable iff (rst)
                            in_valid && !in_ready |=> in_valid && $stable(in_req))
    else begin
      $error("input request dropped or changed before it was accepted");
      fail_count++;
    end

  out_held: assert property (@(posedge clk) disable iff (rst)
                             out_valid && !out_ready |=> out_valid && $stable(out_resp))
    else begin
      $error("output response dropped or changed before it was accepted");
      fail_count++;
    end

  // pipe is two stages deep, nothing can come out sooner
  quiet_after_reset: assert property (@(posedge clk)
                                      !rst && ($past(rst) || $past(rst, 2)) |-> !out_valid)
    else begin
      $error("out_valid high within 2 cycles of reset release");
      fail_count++;
    end

endmodule

bind alu_cluster alu_cluster_checker u_checker (
  .clk       (clk),
  .rst       (rst),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .in_req    (in_req),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_resp  (out_resp)
);

//--- tests/alu_cluster_tb.sv
module alu_cluster_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_LANES    = 4;
  localparam int WAIT_LIMIT = 100;

  logic               clk;
  logic               rst;
  logic               in_valid;
  alu_pkg::alu_req_t  in_req;
  logic               in_ready;
  logic               out_valid;
  alu_pkg::alu_resp_t out_resp;
  logic               out_ready;

  alu_pkg::alu_req_t  vec_req[$];
  alu_pkg::alu_resp_t vec_exp[$];
  int                 vec_grp[$];
  int                 batch_idx[$];

  int check_errors;
  int stalls;
  int tests_run;
  int tests_failed;
  bit collect_done;
  bit saw_in_block;

  alu_cluster #(
    .N_LANES (N_LANES)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_resp  (out_resp),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic load_vectors();
    int                 fd;
    int                 n;
    int                 lines;
    string              line;
    logic [3:0]         grp;
    logic [2:0]         op;
    logic [3:0]         cond;
    logic [63:0]        a;
    logic [63:0]        b;
    logic [3:0]         fin;
    logic [63:0]        res;
    logic [3:0]         fl;
    logic [0:0]         ex;
    alu_pkg::alu_req_t  r;
    alu_pkg::alu_resp_t e;
    fd = $fopen("tests/alu_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/alu_tests.txt");
      check_errors++;
      return;
    end
    lines = 0;
    while (!$feof(fd) && lines < 1000) begin
      lines++;
      n = $fgets(line, fd);
      if (n == 0) begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", grp, op, cond, a, b, fin, res, fl, ex);
      if (n == 9) begin
        r.op       = op;
        r.cond     = cond;
        r.a        = a;
        r.b        = b;
        r.flags_in = fin;
        e.result   = res;
        e.flags    = fl;
        e.executed = ex[0];
        vec_req.push_back(r);
        vec_exp.push_back(e);
        vec_grp.push_back(int'(grp));
      end else if (line.len() > 1 && line.getc(0) != "#") begin
        $display("malformed vector line: %s", line);
        check_errors++;
      end
    end
    $fclose(fd);
  endtask

  // group 0 takes every vector
  function automatic void select_vectors(input int grp);
    batch_idx.delete();
    for (int i = 0; i < vec_req.size(); i++) begin
      if (grp == 0 || vec_grp[i] == grp) begin
        batch_idx.push_back(i);
      end
    end
  endfunction

  task automatic check_response(input int idx, input alu_pkg::alu_resp_t got);
    alu_pkg::alu_resp_t exp;
    exp = vec_exp[idx];
    assert (got.result == exp.result) else begin
      $display("[FAIL] %0t ns: vector %0d result %h, expected %h",
               $time, idx, got.result, exp.result);
      check_errors++;
    end
    // cvnz order
    assert (got.flags == exp.flags) else begin
      $display("[FAIL] %0t ns: vector %0d flags %b, expected %b",
               $time, idx, got.flags, exp.flags);
      check_errors++;
    end
    assert (got.executed == exp.executed) else begin
      $display("[FAIL] %0t ns: vector %0d executed %b, expected %b",
               $time, idx, got.executed, exp.executed);
      check_errors++;
    end
  endtask

  task automatic drive_batch();
    int waited;
    foreach (batch_idx[k]) begin
      in_valid = 1'b1;
      in_req   = vec_req[batch_idx[k]];
      waited   = 0;
      #2;
      while (!in_ready && waited < WAIT_LIMIT) begin
        saw_in_block = 1'b1;
        @(posedge clk);
        #3;
        waited++;
      end
      if (!in_ready) begin
        $display("DUT stalled: in_ready stayed low for %0d cycles at vector %0d",
                 WAIT_LIMIT, batch_idx[k]);
        stalls++;
        return;
      end
      @(posedge clk);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic collect_batch();
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < batch_idx.size() && idle < WAIT_LIMIT) begin
      @(posedge clk);
      #3;
      if (out_valid && out_ready) begin
        check_response(batch_idx[got], out_resp);
        got++;
        idle = 0;
      end else begin
        idle++;
      end
    end
    if (got < batch_idx.size()) begin
      $display("DUT stalled: only %0d of %0d results came out", got, batch_idx.size());
      stalls++;
    end else begin
      // anything still valid here is a duplicate
      for (int k = 0; k < 4; k++) begin
        @(posedge clk);
        #3;
        assert (!out_valid) else begin
          $display("[FAIL] %0t ns: extra result %h after the last one", $time, out_resp.result);
          check_errors++;
        end
      end
    end
    collect_done = 1'b1;
  endtask

  task automatic pace_out_ready(input bit random_ready);
    int cycles;
    cycles = 0;
    while (random_ready && !collect_done && cycles < 20 * WAIT_LIMIT) begin
      @(posedge clk);
      #1;
      // mostly stalled so the lanes fill up
      out_ready = ($urandom % 4) == 0;
      cycles++;
    end
    out_ready = 1'b1;
  endtask

  task automatic run_behavior(input int num, input string name, input int grp,
                              input bit random_ready);
    int errors_before;
    int stalls_before;
    select_vectors(grp);
    errors_before = check_errors;
    stalls_before = stalls;
    collect_done  = 1'b0;
    saw_in_block  = 1'b0;
    fork
      drive_batch();
      collect_batch();
      pace_out_ready(random_ready);
    join
    if (random_ready) begin
      assert (saw_in_block) else begin
        $display("[FAIL] %0t ns: in_ready never fell while the outputs were stalled", $time);
        check_errors++;
      end
    end
    tests_run++;
    if (check_errors == errors_before && stalls == stalls_before) begin
      $display("behavior %0d, %s: ok, %0d vectors", num, name, batch_idx.size());
    end else begin
      tests_failed++;
      $display("behavior %0d, %s: %0d errors, %0d stalls", num, name,
               check_errors - errors_before, stalls - stalls_before);
    end
    // next batch starts just after an edge
    @(posedge clk);
    #1;
  endtask

  initial begin
    void'($urandom(16763));
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_req       = '0;
    out_ready    = 1'b1;
    check_errors = 0;
    stalls       = 0;
    tests_run    = 0;
    tests_failed = 0;
    collect_done = 1'b0;
    saw_in_block = 1'b0;
    load_vectors();
    if (vec_req.size() == 0) begin
      $display("no test vectors were read from tests/alu_tests.txt");
      check_errors++;
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    run_behavior(1, "add and sub", 1, 1'b0);
    if (stalls == 0) begin
      run_behavior(2, "logic and shifts", 2, 1'b0);
    end
    if (stalls == 0) begin
      run_behavior(3, "condition codes", 3, 1'b0);
    end
    if (stalls == 0) begin
      run_behavior(4, "back-to-back issue", 0, 1'b0);
    end
    if (stalls == 0) begin
      run_behavior(5, "random back-pressure", 0, 1'b1);
    end
    $display("%0d behaviors run, %0d failed, %0d check errors, %0d stalls, %0d assertion errors",
             tests_run, tests_failed, check_errors, stalls, uut.u_checker.fail_count);
    if (tests_failed == 0 && check_errors == 0 && stalls == 0 &&
        uut.u_checker.fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- tests/alu_tests.txt
# grp op cond a b flags_in result flags executed, all hex; grp is the behavior number
# a flags digit packs carry, overflow, negative, zero from msb to lsb
1 0 0 0000000000000001 0000000000000002 0 0000000000000003 0 1
1 0 0 ffffffffffffffff 0000000000000001 0 0000000000000000 9 1
1 0 0 7fffffffffffffff 0000000000000001 0 8000000000000000 6 1
1 0 0 8000000000000000 8000000000000000 0 0000000000000000 d 1
1 1 0 0000000000000005 0000000000000003 0 0000000000000002 8 1
1 1 0 0000000000000003 0000000000000005 0 fffffffffffffffe 2 1
1 1 0 8000000000000000 0000000000000001 0 7fffffffffffffff c 1
1 1 0 0000000000000005 0000000000000005 0 0000000000000000 9 1
2 2 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f f000f000f000f000 2 1
2 3 0 00ff00ff00ff00ff 0f0f0f0f0f0f0f0f f 0fff0fff0fff0fff 0 1
2 4 0 123456789abcdef0 123456789abcdef0 f 0000000000000000 1 1
2 5 0 0000000000000001 00000000000000ff f 8000000000000000 2 1
2 5 0 0000000000000001 0000000000000040 f 0000000000000001 0 1
2 6 0 8000000000000000 0000000000000044 f 0800000000000000 0 1
2 7 0 8000000000000000 0000000000000004 f f800000000000000 2 1
2 7 0 7000000000000000 000000000000003c f 0000000000000007 0 1
3 0 0 0000000000000001 0000000000000001 0 0000000000000002 0 1
3 0 1 0000000000000001 0000000000000001 0 0000000000000001 0 0
3 0 2 0000000000000001 0000000000000001 1 0000000000000002 0 1
3 0 3 0000000000000001 0000000000000001 1 0000000000000001 1 0
3 0 4 0000000000000001 0000000000000001 8 0000000000000002 0 1
3 0 5 0000000000000001 0000000000000001 8 0000000000000001 8 0
3 0 6 0000000000000001 0000000000000001 2 0000000000000002 0 1
3 0 7 0000000000000001 0000000000000001 2 0000000000000001 2 0
3 0 8 0000000000000001 0000000000000001 0 0000000000000001 0 0
3 0 9 0000000000000001 0000000000000001 0 0000000000000002 0 1
3 0 a 0000000000000001 0000000000000001 9 0000000000000001 9 0
3 0 b 0000000000000001 0000000000000001 9 0000000000000002 0 1
3 0 c 0000000000000001 0000000000000001 6 0000000000000002 0 1
3 0 d 0000000000000001 0000000000000001 6 0000000000000001 6 0
3 0 e 0000000000000001 0000000000000001 8 0000000000000002 0 1
3 0 f 0000000000000001 0000000000000001 8 0000000000000001 8 0
